//--- source/accelPkg.sv
package accelPkg;

    // sample and line geometry shared by both buffers and the multiplier
    localparam int SAMPLE_W = 64;                 // one complex sample
    localparam int LANES    = 8;                  // samples per host line
    localparam int LINE_W   = SAMPLE_W * LANES;   // 512-bit memory line
    localparam int HALF_W   = 32;                 // real or imag part
    localparam int COEF_W   = 16;                 // coefficient part, fixed point

    // one sample word, seen as raw bits by the buffers
    // and as a signed {imag, real} pair by the multiplier
    typedef union packed {
        logic [SAMPLE_W-1:0] raw;
        struct packed {
            logic signed [HALF_W-1:0] im;         // upper half
            logic signed [HALF_W-1:0] re;         // lower half
        } cplx;
    } sample_t;

endpackage

//--- source/aBufIn.sv
`timescale 1ns/1ps

module aBufIn import accelPkg::*; #(
    parameter int DEPTH = 1024                    // samples per block
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              inReq,              // host line request
    input  logic [LINE_W-1:0] inLine,             // held stable while inReq is high
    input  logic              outFree,            // output buffer can take a block
    output logic              inAck,
    output sample_t           inSample,
    output logic              inValid             // one strobe per sample
);

    localparam int NLINES = DEPTH / LANES;
    localparam int PTR_W  = (NLINES > 1) ? $clog2(NLINES) : 1;
    localparam int CNT_W  = $clog2(NLINES + 1);
    localparam int LANE_W = $clog2(LANES);

    localparam logic [1:0] ST_IDLE   = 2'd0;      // waiting for inReq or a full block
    localparam logic [1:0] ST_ACK    = 2'd1;      // inAck high, waiting for inReq low
    localparam logic [1:0] ST_STREAM = 2'd2;      // pushing samples to the multiplier

    logic [1:0]        state;
    logic [LINE_W-1:0] lineMem [NLINES];
    logic [CNT_W-1:0]  lineCnt;                   // lines stored so far
    logic [PTR_W-1:0]  rdLine;
    logic [LANE_W-1:0] lane;
    logic              full;
    logic              accept;

    assign full   = (lineCnt == CNT_W'(NLINES));
    assign accept = (state == ST_IDLE) && inReq && !full;   // no room means no ack

    // line store, one write per accepted request
    always_ff @(posedge clk) begin
        if (accept) begin
            lineMem[lineCnt[PTR_W-1:0]] <= inLine;
        end
    end

    // lane 0 lives in the top 64 bits of a line
    always_ff @(posedge clk) begin
        if (state == ST_STREAM) begin
            inSample.raw <= lineMem[rdLine][LINE_W-1 - int'(lane)*SAMPLE_W -: SAMPLE_W];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_IDLE;
            inAck   <= 1'b0;
            inValid <= 1'b0;
            lineCnt <= '0;
            rdLine  <= '0;
            lane    <= '0;
        end else begin
            inValid <= 1'b0;                      // strobe only while streaming
            case (state)
                ST_IDLE: begin
                    if (full && outFree) begin
                        state <= ST_STREAM;       // block ready and downstream empty
                    end else if (accept) begin
                        inAck   <= 1'b1;
                        lineCnt <= lineCnt + 1'b1;
                        state   <= ST_ACK;
                    end
                end
                ST_ACK: begin
                    if (!inReq) begin             // host released, finish four-phase
                        inAck <= 1'b0;
                        state <= ST_IDLE;
                    end
                end
                ST_STREAM: begin
                    inValid <= 1'b1;
                    lane    <= lane + 1'b1;       // wraps at LANES
                    if (lane == LANE_W'(LANES - 1)) begin
                        if (rdLine == PTR_W'(NLINES - 1)) begin
                            rdLine  <= '0;        // last sample out, block is empty
                            lineCnt <= '0;
                            state   <= ST_IDLE;
                        end else begin
                            rdLine <= rdLine + 1'b1;
                        end
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

//--- source/cplxMul.sv
`timescale 1ns/1ps

module cplxMul import accelPkg::*; #(
    parameter int COEF_FRAC = 14                  // fractional bits of the coefficient
) (
    input  logic                     clk,
    input  logic                     rst,
    input  sample_t                  inSample,
    input  logic                     inValid,
    input  logic signed [COEF_W-1:0] coefRe,
    input  logic signed [COEF_W-1:0] coefIm,
    output sample_t                  resSample,
    output logic                     resValid     // inValid delayed by two cycles
);

    localparam int PROD_W = HALF_W + COEF_W;      // full partial product

    // stage one partial products
    logic signed [PROD_W-1:0] pRr;                // ar * cr
    logic signed [PROD_W-1:0] pIi;                // ai * ci
    logic signed [PROD_W-1:0] pRi;                // ar * ci
    logic signed [PROD_W-1:0] pIr;                // ai * cr
    logic                     valid1;

    // stage two sums, one bit of headroom before the shift
    logic signed [PROD_W:0]   sumRe;
    logic signed [PROD_W:0]   sumIm;

    always_ff @(posedge clk) begin
        pRr <= $signed(inSample.cplx.re) * coefRe;
        pIi <= $signed(inSample.cplx.im) * coefIm;
        pRi <= $signed(inSample.cplx.re) * coefIm;
        pIr <= $signed(inSample.cplx.im) * coefRe;
    end

    // arithmetic shift drops the fraction, truncates toward minus infinity
    always_comb begin
        sumRe = (pRr - pIi) >>> COEF_FRAC;
        sumIm = (pRi + pIr) >>> COEF_FRAC;
    end

    always_ff @(posedge clk) begin
        resSample.cplx.re <= sumRe[HALF_W-1:0];   // wraps, no saturation
        resSample.cplx.im <= sumIm[HALF_W-1:0];
    end

    // valid runs alongside the data, pipeline never stalls
    always_ff @(posedge clk) begin
        if (rst) begin
            valid1   <= 1'b0;
            resValid <= 1'b0;
        end else begin
            valid1   <= inValid;
            resValid <= valid1;
        end
    end

endmodule

//--- source/aBufOut.sv
`timescale 1ns/1ps

module aBufOut import accelPkg::*; #(
    parameter int DEPTH = 1024                    // samples per block
) (
    input  logic              clk,
    input  logic              rst,
    input  sample_t           resSample,
    input  logic              resValid,
    input  logic              outAck,             // memory controller acknowledge
    output logic              outReq,
    output logic [LINE_W-1:0] outLine,
    output logic              outFree             // empty, idle, nothing received
);

    localparam int NLINES = DEPTH / LANES;
    localparam int IDX_W  = $clog2(DEPTH);
    localparam int PTR_W  = (NLINES > 1) ? $clog2(NLINES) : 1;

    localparam logic [1:0] ST_FILL = 2'd0;        // collecting results
    localparam logic [1:0] ST_REQ  = 2'd1;        // outReq high, waiting for outAck
    localparam logic [1:0] ST_WAIT = 2'd2;        // waiting for outAck to fall

    logic [SAMPLE_W-1:0] store [DEPTH];           // one block of results
    logic [IDX_W-1:0]    wrIdx;
    logic [PTR_W-1:0]    rdLine;                  // line being presented
    logic [1:0]          state;
    logic                lastIn;

    assign lastIn = resValid && (wrIdx == IDX_W'(DEPTH - 1));

    always_ff @(posedge clk) begin
        if (resValid) begin
            store[wrIdx] <= resSample.raw;
        end
    end

    // pack LANES consecutive samples, first one at the top
    always_comb begin
        for (int k = 0; k < LANES; k++) begin
            outLine[LINE_W-1 - k*SAMPLE_W -: SAMPLE_W] =
                store[IDX_W'(int'(rdLine) * LANES + k)];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= ST_FILL;
            outReq  <= 1'b0;
            outFree <= 1'b1;
            wrIdx   <= '0;
            rdLine  <= '0;
        end else begin
            case (state)
                ST_FILL: begin
                    if (resValid) begin
                        outFree <= 1'b0;          // a block has begun
                        if (lastIn) begin
                            wrIdx  <= '0;
                            outReq <= 1'b1;       // drain starts next cycle
                            state  <= ST_REQ;
                        end else begin
                            wrIdx <= wrIdx + 1'b1;
                        end
                    end
                end
                ST_REQ: begin
                    if (outAck) begin
                        outReq <= 1'b0;
                        state  <= ST_WAIT;
                        if (rdLine == PTR_W'(NLINES - 1)) begin
                            rdLine <= '0;
                        end else begin
                            rdLine <= rdLine + 1'b1;
                        end
                    end
                end
                ST_WAIT: begin
                    if (!outAck) begin
                        if (rdLine == '0) begin   // pointer wrapped, all lines gone
                            outFree <= 1'b1;
                            state   <= ST_FILL;
                        end else begin
                            outReq <= 1'b1;       // next line
                            state  <= ST_REQ;
                        end
                    end
                end
                default: state <= ST_FILL;
            endcase
        end
    end

endmodule

//--- source/accelTop.sv
`timescale 1ns/1ps

module accelTop import accelPkg::*; #(
    parameter int DEPTH     = 1024,               // samples per block, multiple of LANES
    parameter int COEF_FRAC = 14
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inReq,
    input  logic [LINE_W-1:0]        inLine,
    input  logic                     outAck,
    input  logic signed [COEF_W-1:0] coefRe,      // change only between blocks
    input  logic signed [COEF_W-1:0] coefIm,
    output logic                     inAck,
    output logic                     outReq,
    output logic [LINE_W-1:0]        outLine
);

    sample_t inSample;                            // input buffer to multiplier
    logic    inValid;
    sample_t resSample;                           // multiplier to output buffer
    logic    resValid;
    logic    outFree;                             // lets the next block start

    aBufIn #(.DEPTH(DEPTH)) bufIn_i (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inLine(inLine),
        .outFree(outFree),
        .inAck(inAck),
        .inSample(inSample),
        .inValid(inValid)
    );

    cplxMul #(.COEF_FRAC(COEF_FRAC)) mul_i (
        .clk(clk),
        .rst(rst),
        .inSample(inSample),
        .inValid(inValid),
        .coefRe(coefRe),
        .coefIm(coefIm),
        .resSample(resSample),
        .resValid(resValid)
    );

    aBufOut #(.DEPTH(DEPTH)) bufOut_i (
        .clk(clk),
        .rst(rst),
        .resSample(resSample),
        .resValid(resValid),
        .outAck(outAck),
        .outReq(outReq),
        .outLine(outLine),
        .outFree(outFree)
    );

endmodule

//--- include/accelTbUtil.svh
`ifndef ACCEL_TB_UTIL_SVH
`define ACCEL_TB_UTIL_SVH

// 32-bit LCG step, numerical recipes constants
function automatic logic [31:0] lcgNext(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// two LCG steps give one sample, imag from the first
function automatic logic [accelPkg::SAMPLE_W-1:0] lcgSample(inout logic [31:0] state);
    logic [31:0] hi;
    state = lcgNext(state);
    hi    = state;
    state = lcgNext(state);
    return {hi, state};
endfunction

// model of the multiplier, same truncation and wrap
function automatic logic [accelPkg::SAMPLE_W-1:0] refMul(
    input logic [accelPkg::SAMPLE_W-1:0]      smp,
    input logic signed [accelPkg::COEF_W-1:0] cRe,
    input logic signed [accelPkg::COEF_W-1:0] cIm,
    input int                                 frac
);
    logic signed [accelPkg::HALF_W-1:0] aRe;
    logic signed [accelPkg::HALF_W-1:0] aIm;
    longint                             pRe;
    longint                             pIm;
    aRe = smp[accelPkg::HALF_W-1:0];
    aIm = smp[accelPkg::SAMPLE_W-1:accelPkg::HALF_W];
    pRe = (longint'(aRe) * longint'(cRe) - longint'(aIm) * longint'(cIm)) >>> frac;
    pIm = (longint'(aRe) * longint'(cIm) + longint'(aIm) * longint'(cRe)) >>> frac;
    return {pIm[accelPkg::HALF_W-1:0], pRe[accelPkg::HALF_W-1:0]};
endfunction

// lane 0 goes to the top of the line
function automatic logic [accelPkg::LINE_W-1:0] packLine(
    input logic [accelPkg::SAMPLE_W-1:0] lanes [accelPkg::LANES]
);
    logic [accelPkg::LINE_W-1:0] line;
    for (int k = 0; k < accelPkg::LANES; k++) begin
        line[accelPkg::LINE_W-1 - k*accelPkg::SAMPLE_W -: accelPkg::SAMPLE_W] = lanes[k];
    end
    return line;
endfunction

function automatic logic [accelPkg::SAMPLE_W-1:0] getLane(
    input logic [accelPkg::LINE_W-1:0] line,
    input int                          k
);
    return line[accelPkg::LINE_W-1 - k*accelPkg::SAMPLE_W -: accelPkg::SAMPLE_W];
endfunction

`endif

//--- tb/accelTb.sv
`timescale 1ns/1ps

module accelTb import accelPkg::*; ();

    localparam int DEPTH     = 32;                // small block keeps the run short
    localparam int COEF_FRAC = 14;
    localparam int NLINES    = DEPTH / LANES;
    localparam int HS_LIMIT  = 1000;              // cycles allowed for one handshake phase
    localparam int N_BLOCKS  = 6;                 // blocks over all tests
    localparam int WD_CYCLES = 200 * N_BLOCKS + 500;

    `include "accelTbUtil.svh"

    logic                     clk;
    logic                     rst;
    logic                     inReq;
    logic [LINE_W-1:0]        inLine;
    logic                     outAck;
    logic signed [COEF_W-1:0] coefRe;
    logic signed [COEF_W-1:0] coefIm;
    logic                     inAck;
    logic                     outReq;
    logic [LINE_W-1:0]        outLine;

    logic [31:0]              seed;               // LCG state
    logic [LINE_W-1:0]        sendQ [$];          // host lines, in send order
    logic [LINE_W-1:0]        expQ [$];           // expected result lines
    logic signed [COEF_W-1:0] blkRe [3];          // coefficient per block
    logic signed [COEF_W-1:0] blkIm [3];
    string                    curTest;
    int                       checks;
    int                       mismatches;
    int                       timeouts;
    int                       protoErrs;

    accelTop #(.DEPTH(DEPTH), .COEF_FRAC(COEF_FRAC)) dut_i (
        .clk(clk),
        .rst(rst),
        .inReq(inReq),
        .inLine(inLine),
        .outAck(outAck),
        .coefRe(coefRe),
        .coefIm(coefIm),
        .inAck(inAck),
        .outReq(outReq),
        .outLine(outLine)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;                    // 4 ns period
    end

    // ends a stuck run, sized from the number of blocks
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles in test %s", WD_CYCLES, curTest);
        $display("Test failed");
        $finish;
    end

    // host writes one line, four-phase
    task automatic sendLine(input logic [LINE_W-1:0] line);
        int n;
        inLine = line;
        inReq  = 1'b1;
        n = 0;
        while (!inAck && n < HS_LIMIT) begin      // no ack while the block is full
            @(posedge clk);
            #1;
            n++;
        end
        if (!inAck) begin
            $display("%s: inAck never rose for a host line", curTest);
            timeouts++;
        end
        inReq = 1'b0;
        n = 0;
        while (inAck && n < HS_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (inAck) begin
            $display("%s: inAck stayed high after inReq fell", curTest);
            timeouts++;
        end
    endtask

    // host takes one result line, outAck raised after delay cycles
    task automatic recvLine(input int delay, output logic [LINE_W-1:0] line);
        int n;
        n = 0;
        while (!outReq && n < HS_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!outReq) begin
            $display("%s: outReq never rose for a result line", curTest);
            timeouts++;
        end
        line = outLine;
        for (int d = 0; d < delay; d++) begin
            @(posedge clk);
            #1;
            if (!outReq) begin                    // must hold until acknowledged
                $display("%s: outReq fell before outAck was raised", curTest);
                protoErrs++;
            end
        end
        outAck = 1'b1;
        n = 0;
        while (outReq && n < HS_LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (outReq) begin
            $display("%s: outReq stayed high after outAck", curTest);
            timeouts++;
        end
        outAck = 1'b0;
    endtask

    task automatic pickCoef(output logic signed [COEF_W-1:0] c);
        seed = lcgNext(seed);
        c    = seed[31:16];                       // top bits, sign included
    endtask

    // one block of random samples and the lines expected back
    task automatic makeBlock(input logic signed [COEF_W-1:0] cRe,
                             input logic signed [COEF_W-1:0] cIm);
        logic [SAMPLE_W-1:0] src [LANES];
        logic [SAMPLE_W-1:0] res [LANES];
        for (int l = 0; l < NLINES; l++) begin
            for (int k = 0; k < LANES; k++) begin
                src[k] = lcgSample(seed);
                res[k] = refMul(src[k], cRe, cIm, COEF_FRAC);
            end
            sendQ.push_back(packLine(src));
            expQ.push_back(packLine(res));
        end
    endtask

    // sender and receiver run side by side, coef moves on between blocks
    task automatic runBlocks(input int nBlk, input int maxDelay);
        logic [LINE_W-1:0] got;
        int                dly;
        int                idx;
        int                bad;
        coefRe = blkRe[0];
        coefIm = blkIm[0];
        fork
            begin
                for (int i = 0; i < nBlk * NLINES; i++) begin
                    sendLine(sendQ[i]);
                end
            end
            begin
                for (int b = 0; b < nBlk; b++) begin
                    for (int l = 0; l < NLINES; l++) begin
                        seed = lcgNext(seed);
                        dly  = int'(seed[31:24]) % (maxDelay + 1);
                        recvLine(dly, got);
                        idx = b * NLINES + l;
                        checks++;
                        if (got !== expQ[idx]) begin
                            bad = -1;
                            for (int k = LANES - 1; k >= 0; k--) begin   // lowest bad lane
                                if (getLane(got, k) !== getLane(expQ[idx], k)) begin
                                    bad = k;
                                end
                            end
                            $display("[FAIL] %s line %0d lane %0d: expected %h actual %h",
                                     curTest, idx, bad, expQ[idx], got);
                            mismatches++;
                        end
                    end
                    if (b + 1 < nBlk) begin       // block fully drained, safe to switch
                        coefRe = blkRe[b + 1];
                        coefIm = blkIm[b + 1];
                    end
                end
            end
        join
        sendQ.delete();
        expQ.delete();
    endtask

    task automatic testReset();
        curTest = "reset";
        checks++;
        if (inAck !== 1'b0) begin
            $display("[FAIL] %s inAck: expected 0 actual %b", curTest, inAck);
            mismatches++;
        end
        if (outReq !== 1'b0) begin
            $display("[FAIL] %s outReq: expected 0 actual %b", curTest, outReq);
            mismatches++;
        end
        repeat (20) begin                         // idle, nothing may come out
            @(posedge clk);
            #1;
            if (outReq !== 1'b0) begin
                $display("[FAIL] %s idle outReq: expected 0 actual %b", curTest, outReq);
                mismatches++;
            end
        end
    endtask

    task automatic testIdentity();
        curTest  = "identity";
        blkRe[0] = 16'sd16384;                    // 1.0 in Q14
        blkIm[0] = 16'sd0;
        makeBlock(blkRe[0], blkIm[0]);
        expQ = sendQ;                             // unit coefficient returns the input
        runBlocks(1, 0);
    endtask

    task automatic testScaling();
        curTest = "scaling";
        pickCoef(blkRe[0]);
        pickCoef(blkIm[0]);
        makeBlock(blkRe[0], blkIm[0]);
        runBlocks(1, 0);
    endtask

    task automatic testBackPressure();
        curTest = "backpressure";
        pickCoef(blkRe[0]);
        pickCoef(blkIm[0]);
        makeBlock(blkRe[0], blkIm[0]);
        runBlocks(1, 7);                          // up to 7 cycles before outAck
    endtask

    task automatic testBackToBack();
        curTest = "backtoback";
        for (int b = 0; b < 3; b++) begin
            pickCoef(blkRe[b]);
            pickCoef(blkIm[b]);
            makeBlock(blkRe[b], blkIm[b]);
        end
        runBlocks(3, 3);
    endtask

    initial begin
        rst        = 1'b1;
        inReq      = 1'b0;
        inLine     = '0;
        outAck     = 1'b0;
        coefRe     = '0;
        coefIm     = '0;
        seed       = 32'd40570;
        curTest    = "startup";
        checks     = 0;
        mismatches = 0;
        timeouts   = 0;
        protoErrs  = 0;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;
        testReset();
        testIdentity();
        testScaling();
        testBackPressure();
        testBackToBack();
        $display("checks %0d, mismatches %0d, handshake timeouts %0d, protocol errors %0d",
                 checks, mismatches, timeouts, protoErrs);
        if (mismatches + timeouts + protoErrs == 0 && checks > 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+include
source/accelPkg.sv
source/aBufIn.sv
source/cplxMul.sv
source/aBufOut.sv
source/accelTop.sv
tb/accelTb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module accelTb -f files.f &&
./obj_dir/VaccelTb | tee /dev/stderr | grep -q "Test completed successfully" &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
